/* verilog.f */
+incdir+test
source/wg_pkg.sv
source/wg_txn_fifo.sv
source/wg_aw_stage.sv
source/wg_w_stage.sv
source/wg_b_stage.sv
source/wg_fault_ctrl.sv
source/write_guard.sv
test/wg_sva.sv
test/wg_checker.sv
test/tb_write_guard.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the write guard simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_write_guard -o sim_write_guard
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_write_guard)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

/* test/wg_tb_types.svh */
/*
 * Write guard testbench row type
 * One stimulus table row with its budgets and expected fault code
 */
`ifndef WG_TB_TYPES_SVH
`define WG_TB_TYPES_SVH

typedef struct packed {
  wg_pkg::id_t         id;
  wg_pkg::len_t        len;
  wg_pkg::cnt_t        aw_delay;
  wg_pkg::cnt_t        w_gap;
  wg_pkg::cnt_t        b_delay;
  logic                bad_bid;
  logic                multi;
  wg_pkg::budget_t     budget;
  wg_pkg::fault_code_e exp_code;
} row_t;

`endif

/* test/tb_write_guard.sv */
/*
 * Write guard testbench
 * Plays a table of AXI writes on the observed bus and reports the result
 */
`timescale 1ns/10ps
`include "wg_tb_types.svh"

module tb_write_guard import wg_pkg::*; ();

  localparam int NumRows = 8;

  logic     clk_i, rst_ni, reset_clear_i, row_done;
  aw_chan_t aw_ch;
  w_chan_t  w_ch;
  b_chan_t  b_ch;
  budget_t  budget;
  logic     irq_o, reset_req_o, latency_valid_o;
  latency_t latency_o;
  fault_t   fault_o;
  row_t     rows [NumRows];
  row_t     cur_row;
  logic     aborted;
  int       mismatch_cnt, fail_cnt;

  write_guard UUT (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .aw_i            (aw_ch),
    .w_i             (w_ch),
    .b_i             (b_ch),
    .budget_i        (budget),
    .reset_clear_i   (reset_clear_i),
    .irq_o           (irq_o),
    .reset_req_o     (reset_req_o),
    .latency_valid_o (latency_valid_o),
    .latency_o       (latency_o),
    .fault_o         (fault_o)
  );

  wg_checker i_checker (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .row_i           (cur_row),
    .row_done_i      (row_done),
    .irq_o           (irq_o),
    .reset_req_o     (reset_req_o),
    .latency_valid_o (latency_valid_o),
    .latency_o       (latency_o),
    .fault_o         (fault_o),
    .mismatch_cnt_o  (mismatch_cnt),
    .fail_cnt_o      (fail_cnt)
  );

  bind write_guard wg_sva i_sva (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .irq_o           (irq_o),
    .reset_req_o     (reset_req_o),
    .latency_valid_o (latency_valid_o),
    .reset_clear_i   (reset_clear_i),
    .fault_o         (fault_o)
  );

  always #5 clk_i = ~clk_i;

  // Next cycle with an idle bus
  // Once irq is up the rest of the write is dropped
  task automatic step();
    @(posedge clk_i);
    #1;
    aw_ch         = '0;
    w_ch          = '0;
    b_ch          = '0;
    reset_clear_i = 1'b0;
    row_done      = 1'b0;
    if (irq_o) begin
      aborted = 1'b1;
    end
  endtask

  task automatic play_row(input row_t r);
    int n;
    n = r.multi ? 3 : 1;
    aborted = 1'b0;
    budget  = r.budget;
    for (int k = 0; k < n; k++) begin
      for (int j = 0; j <= int'(r.aw_delay); j++) begin
        step();
        if (!aborted) begin
          aw_ch = '{valid: 1'b1, ready: (j == int'(r.aw_delay)),
                    id: r.id + id_t'(k), len: r.len};
        end
      end
    end
    for (int k = 0; k < n; k++) begin
      for (int b = 0; b <= int'(r.len); b++) begin
        if (b != 0) begin
          repeat (int'(r.w_gap)) step();
        end
        step();
        if (!aborted) begin
          w_ch = '{valid: 1'b1, ready: 1'b1, last: (b == int'(r.len))};
        end
      end
      for (int j = 1; j < int'(r.b_delay); j++) begin
        step();
      end
      step();
      if (!aborted) begin
        b_ch = '{valid: 1'b1, ready: 1'b1,
                 id: r.bad_bid ? ((r.id + id_t'(k)) ^ id_t'(1)) : (r.id + id_t'(k))};
      end
    end
    step();
  endtask

  initial begin
    budget_t loose;
    loose    = '{aw_wait: 8'd10, w_ready: 8'd10, w_per_beat: 8'd4, b_wait: 8'd20};
    rows[0]  = '{4'h1, 8'd0, 8'd0, 8'd0, 8'd1, 1'b0, 1'b0, loose, NONE};
    rows[1]  = '{4'h2, 8'd3, 8'd2, 8'd0, 8'd3, 1'b0, 1'b0, loose, NONE};
    rows[2]  = '{4'h3, 8'd0, 8'd6, 8'd0, 8'd1, 1'b0, 1'b0,
                 '{aw_wait: 8'd3, w_ready: 8'd10, w_per_beat: 8'd4, b_wait: 8'd20}, AW_STALL};
    rows[3]  = '{4'h4, 8'd1, 8'd0, 8'd2, 8'd1, 1'b0, 1'b0,
                 '{aw_wait: 8'd10, w_ready: 8'd10, w_per_beat: 8'd1, b_wait: 8'd20}, W_BURST};
    rows[4]  = '{4'h5, 8'd2, 8'd1, 8'd1, 8'd2, 1'b0, 1'b0, loose, NONE};
    rows[5]  = '{4'h6, 8'd0, 8'd0, 8'd0, 8'd2, 1'b1, 1'b0, loose, UNWANTED_RESP};
    rows[6]  = '{4'h7, 8'd0, 8'd0, 8'd0, 8'd8, 1'b0, 1'b0,
                 '{aw_wait: 8'd10, w_ready: 8'd10, w_per_beat: 8'd4, b_wait: 8'd4}, B_TIMEOUT};
    rows[7]  = '{4'h8, 8'd1, 8'd1, 8'd0, 8'd2, 1'b0, 1'b1, loose, NONE};

    void'($urandom(72));
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    reset_clear_i = 1'b0;
    row_done      = 1'b0;
    aborted       = 1'b0;
    aw_ch         = '0;
    w_ch          = '0;
    b_ch          = '0;
    budget        = loose;
    cur_row       = rows[0];
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    for (int i = 0; i < NumRows; i++) begin
      cur_row = rows[i];
      play_row(rows[i]);
      repeat (3 + $urandom % 4) step();
      if (rows[i].exp_code != NONE) begin
        reset_clear_i = 1'b1;
        step();
        step();
      end
      row_done = 1'b1;
      step();
    end
    repeat (2) step();

    $display("Error counts: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (NumRows * 200) @(posedge clk_i);
    $display("Timeout: the test sequence did not finish in time");
    $display("tests failed");
    $finish;
  end

endmodule

/* test/wg_checker.sv */
/*
 * Write guard checker
 * Watches the DUT outputs and compares them with the current table row
 */
`timescale 1ns/10ps
`include "wg_tb_types.svh"

module wg_checker import wg_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  row_t     row_i,
  input  logic     row_done_i,
  input  logic     irq_o,
  input  logic     reset_req_o,
  input  logic     latency_valid_o,
  input  latency_t latency_o,
  input  fault_t   fault_o,
  output int       mismatch_cnt_o,
  output int       fail_cnt_o
);

  int   rec_cnt;
  logic irq_seen;

  // Record k of a row follows the write with id + k
  function automatic latency_t expected_latency(row_t r, int k);
    int w_cycles;
    w_cycles = (int'(r.len) + 1) + int'(r.len) * int'(r.w_gap);
    return '{id: r.id + id_t'(k), aw_wait: r.aw_delay,
             w_cycles: cnt_t'(w_cycles), b_wait: r.b_delay};
  endfunction

  function automatic int expected_records(row_t r);
    if (r.exp_code != NONE) begin
      return 0;
    end
    return r.multi ? 3 : 1;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      mismatch_cnt_o++;
    end
  endtask

  task automatic fail(input string what);
    $display("ERROR %s", what);
    fail_cnt_o++;
  endtask

  initial begin
    mismatch_cnt_o = 0;
    fail_cnt_o     = 0;
    rec_cnt        = 0;
    irq_seen       = 1'b0;
  end

  always @(posedge clk_i) begin
    latency_t    exp;
    fault_code_e code;
    id_t         exp_id;
    logic        exp_rst;
    if (rst_ni) begin
      if (latency_valid_o) begin
        if (rec_cnt >= expected_records(row_i)) begin
          fail("latency record that was not expected");
        end else begin
          exp = expected_latency(row_i, rec_cnt);
          compare("latency_o.id", 32'(latency_o.id), 32'(exp.id));
          compare("latency_o.aw_wait", 32'(latency_o.aw_wait), 32'(exp.aw_wait));
          compare("latency_o.w_cycles", 32'(latency_o.w_cycles), 32'(exp.w_cycles));
          compare("latency_o.b_wait", 32'(latency_o.b_wait), 32'(exp.b_wait));
        end
        rec_cnt++;
      end
      if (irq_o && !irq_seen) begin
        irq_seen = 1'b1;
        code     = row_i.exp_code;
        if (code == NONE) begin
          fail("irq raised on a clean write");
        end else begin
          // A stray response reports the id seen on B
          exp_id  = (code == UNWANTED_RESP) ? (row_i.id ^ id_t'(1)) : row_i.id;
          exp_rst = (code == AW_STALL) || (code == W_STALL) || (code == UNWANTED_RESP);
          compare("fault_o.valid", 32'(fault_o.valid), 32'(1'b1));
          compare("fault_o.code", 32'(fault_o.code), 32'(code));
          compare("fault_o.id", 32'(fault_o.id), 32'(exp_id));
          compare("reset_req_o", 32'(reset_req_o), 32'(exp_rst));
        end
      end
      if (row_done_i) begin
        if (rec_cnt < expected_records(row_i)) begin
          fail("latency record missing");
        end
        if (row_i.exp_code != NONE && !irq_seen) begin
          fail("irq missing for a faulting write");
        end
        if (irq_o || reset_req_o || fault_o.valid) begin
          fail("irq, reset request or fault record not cleared");
        end
        compare("fault_o.code", 32'(fault_o.code), 32'(NONE));
        rec_cnt  = 0;
        irq_seen = 1'b0;
      end
    end
  end

endmodule

/* test/wg_sva.sv */
/*
 * Write guard assertions
 * Output protocol rules, bound onto the top level
 */
`timescale 1ns/10ps

module wg_sva import wg_pkg::*; (
  input logic   clk_i,
  input logic   rst_ni,
  input logic   irq_o,
  input logic   reset_req_o,
  input logic   latency_valid_o,
  input logic   reset_clear_i,
  input fault_t fault_o
);

  a_latency_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    latency_valid_o |=> !latency_valid_o)
    else $error("latency_valid_o high for two cycles");

  a_reset_req_irq: assert property (@(posedge clk_i) disable iff (!rst_ni)
    reset_req_o |-> irq_o)
    else $error("reset_req_o without irq_o");

  // Fault record holds until a clear arrives
  a_fault_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (irq_o && !reset_clear_i) |=> $stable(fault_o))
    else $error("fault_o changed while irq_o high");

endmodule

/* source/write_guard.sv */
/*
 * AXI write guard
 * Passive monitor that times the AW, W and B phases of every write in order
 */
`timescale 1ns/10ps

module write_guard import wg_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  aw_chan_t aw_i,
  input  w_chan_t  w_i,
  input  b_chan_t  b_i,
  input  budget_t  budget_i,
  input  logic     reset_clear_i,
  output logic     irq_o,
  output logic     reset_req_o,
  output logic     latency_valid_o,
  output latency_t latency_o,
  output fault_t   fault_o
);

  logic      flush;
  logic      aw_push, aw_full, aw_empty, w_pop;
  aw_entry_t aw_entry, aw_head;
  logic      b_push, b_empty, b_pop;
  b_entry_t  b_entry, b_head;
  fault_t    aw_fault, w_fault, b_fault;

  wg_aw_stage i_aw_stage (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush),
    .aw_i        (aw_i),
    .budget_i    (budget_i),
    .fifo_full_i (aw_full),
    .push_o      (aw_push),
    .entry_o     (aw_entry),
    .fault_o     (aw_fault)
  );

  // Writes waiting for their data burst
  wg_txn_fifo #(
    .entry_t (aw_entry_t)
  ) i_aw_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush),
    .push_i  (aw_push),
    .data_i  (aw_entry),
    .pop_i   (w_pop),
    .data_o  (aw_head),
    .empty_o (aw_empty),
    .full_o  (aw_full)
  );

  wg_w_stage i_w_stage (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush),
    .w_i          (w_i),
    .budget_i     (budget_i),
    .head_i       (aw_head),
    .head_valid_i (!aw_empty),
    .pop_o        (w_pop),
    .push_o       (b_push),
    .entry_o      (b_entry),
    .fault_o      (w_fault)
  );

  // Writes waiting for their response
  wg_txn_fifo #(
    .entry_t (b_entry_t)
  ) i_b_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .flush_i (flush),
    .push_i  (b_push),
    .data_i  (b_entry),
    .pop_i   (b_pop),
    .data_o  (b_head),
    .empty_o (b_empty),
    .full_o  ()
  );

  wg_b_stage i_b_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush),
    .b_i             (b_i),
    .budget_i        (budget_i),
    .head_i          (b_head),
    .head_valid_i    (!b_empty),
    .pop_o           (b_pop),
    .latency_valid_o (latency_valid_o),
    .latency_o       (latency_o),
    .fault_o         (b_fault)
  );

  wg_fault_ctrl i_fault_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .aw_fault_i    (aw_fault),
    .w_fault_i     (w_fault),
    .b_fault_i     (b_fault),
    .reset_clear_i (reset_clear_i),
    .irq_o         (irq_o),
    .reset_req_o   (reset_req_o),
    .fault_o       (fault_o),
    .flush_o       (flush)
  );

endmodule

/* source/wg_fault_ctrl.sv */
/*
 * Fault controller
 * Keeps the first fault, drives sticky irq and reset request, flushes the stages
 */
`timescale 1ns/10ps

module wg_fault_ctrl import wg_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  fault_t aw_fault_i,
  input  fault_t w_fault_i,
  input  fault_t b_fault_i,
  input  logic   reset_clear_i,
  output logic   irq_o,
  output logic   reset_req_o,
  output fault_t fault_o,
  output logic   flush_o
);

  logic   irq_q, reset_req_q, flush_q;
  fault_t fault_q;
  fault_t sel;
  logic   reset_class;

  // Later phases win because they belong to older writes
  always_comb begin
    if (b_fault_i.valid) begin
      sel = b_fault_i;
    end else if (w_fault_i.valid) begin
      sel = w_fault_i;
    end else begin
      sel = aw_fault_i;
    end
  end

  // Stalls and stray responses need the bus reset
  assign reset_class = sel.code inside {AW_STALL, W_STALL, UNWANTED_RESP};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_q       <= 1'b0;
      reset_req_q <= 1'b0;
      flush_q     <= 1'b0;
      fault_q     <= '{valid: 1'b0, code: NONE, id: '0};
    end else begin
      flush_q <= 1'b0;
      if (!irq_q && sel.valid) begin
        irq_q       <= 1'b1;
        reset_req_q <= reset_class;
        flush_q     <= 1'b1;
        fault_q     <= sel;
      end else if (reset_clear_i) begin
        irq_q       <= 1'b0;
        reset_req_q <= 1'b0;
        fault_q     <= '{valid: 1'b0, code: NONE, id: '0};
      end
    end
  end

  assign irq_o       = irq_q;
  assign reset_req_o = reset_req_q;
  assign fault_o     = fault_q;
  assign flush_o     = flush_q;

endmodule

/* source/wg_b_stage.sv */
/*
 * Response phase stage
 * Times the response of the oldest write, matches B ids, emits latency records
 */
`timescale 1ns/10ps

module wg_b_stage import wg_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     flush_i,
  input  b_chan_t  b_i,
  input  budget_t  budget_i,
  input  b_entry_t head_i,
  input  logic     head_valid_i,
  output logic     pop_o,
  output logic     latency_valid_o,
  output latency_t latency_o,
  output fault_t   fault_o
);

  cnt_t     wait_q;
  logic     latency_valid_q;
  latency_t latency_q;

  logic b_hs, id_match, timeout, unwanted;
  cnt_t wait_cnt;

  assign b_hs     = b_i.valid && b_i.ready;
  assign id_match = head_valid_i && (b_i.id == head_i.id);

  // Cycles since the W last handshake including this one
  assign wait_cnt = sat_inc(wait_q);

  assign timeout  = head_valid_i && (wait_cnt > budget_i.b_wait);
  assign unwanted = b_hs && !id_match;
  assign pop_o    = b_hs && id_match;

  // Counting restarts whenever a new write reaches the head
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wait_q <= '0;
    end else if (flush_i || pop_o) begin
      wait_q <= '0;
    end else if (head_valid_i) begin
      wait_q <= wait_cnt;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      latency_valid_q <= 1'b0;
    end else begin
      latency_valid_q <= pop_o && !timeout;
    end
  end

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      latency_q <= '{
        id:       head_i.id,
        aw_wait:  head_i.aw_wait,
        w_cycles: head_i.w_cycles,
        b_wait:   wait_cnt
      };
    end
  end

  assign latency_valid_o = latency_valid_q;
  assign latency_o       = latency_q;

  always_comb begin
    fault_o = '{valid: 1'b0, code: NONE, id: '0};
    if (unwanted) begin
      fault_o = '{valid: 1'b1, code: UNWANTED_RESP, id: b_i.id};
    end else if (timeout) begin
      fault_o = '{valid: 1'b1, code: B_TIMEOUT, id: head_i.id};
    end
  end

endmodule

/* source/wg_w_stage.sv */
/*
 * Data phase stage
 * Times the burst of the oldest write, checks its beat count and hands it to B
 */
`timescale 1ns/10ps

module wg_w_stage import wg_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  w_chan_t   w_i,
  input  budget_t   budget_i,
  input  aw_entry_t head_i,
  input  logic      head_valid_i,
  output logic      pop_o,
  output logic      push_o,
  output b_entry_t  entry_o,
  output fault_t    fault_o
);

  logic active_q;
  cnt_t burst_q;
  cnt_t stall_q;
  len_t beat_q;

  logic w_hs, last_hs, in_burst;
  cnt_t burst_cnt;
  logic stall_over, burst_over, len_err;

  // Beats only count while a write is waiting for data
  assign w_hs     = head_valid_i && w_i.valid && w_i.ready;
  assign last_hs  = w_hs && w_i.last;
  assign in_burst = active_q || w_hs;

  // Burst length so far including this cycle
  assign burst_cnt = active_q ? sat_inc(burst_q) : cnt_t'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      burst_q  <= '0;
      beat_q   <= '0;
      stall_q  <= '0;
    end else if (flush_i || last_hs) begin
      active_q <= 1'b0;
      burst_q  <= '0;
      beat_q   <= '0;
      stall_q  <= '0;
    end else begin
      if (w_hs) begin
        active_q <= 1'b1;
        beat_q   <= beat_q + 1'b1;
      end
      if (in_burst) begin
        burst_q <= burst_cnt;
      end
      if (head_valid_i && w_i.valid && !w_i.ready) begin
        stall_q <= sat_inc(stall_q);
      end
    end
  end

  assign stall_over = stall_q > budget_i.w_ready;
  assign burst_over = in_burst && (burst_cnt > head_i.w_budget);

  // Early last, or a beat past len that is not flagged last
  assign len_err = w_hs && (w_i.last ? (beat_q != head_i.len) : (beat_q == head_i.len));

  assign pop_o   = last_hs;
  assign push_o  = last_hs;
  assign entry_o = '{id: head_i.id, aw_wait: head_i.aw_wait, w_cycles: burst_cnt};

  always_comb begin
    fault_o = '{valid: 1'b0, code: NONE, id: '0};
    if (stall_over) begin
      fault_o = '{valid: 1'b1, code: W_STALL, id: head_i.id};
    end else if (burst_over) begin
      fault_o = '{valid: 1'b1, code: W_BURST, id: head_i.id};
    end else if (len_err) begin
      fault_o = '{valid: 1'b1, code: W_LEN, id: head_i.id};
    end
  end

endmodule

/* source/wg_aw_stage.sv */
/*
 * Address phase stage
 * Times AW stalls and enqueues each accepted write with its burst budget
 */
`timescale 1ns/10ps

module wg_aw_stage import wg_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      flush_i,
  input  aw_chan_t  aw_i,
  input  budget_t   budget_i,
  input  logic      fifo_full_i,
  output logic      push_o,
  output aw_entry_t entry_o,
  output fault_t    fault_o
);

  localparam int unsigned ProdWidth = CntWidth + LenWidth + 1;

  cnt_t stall_q;
  logic aw_hs, aw_stall;
  logic stall_over, overflow;
  logic [LenWidth:0]    beats;
  logic [ProdWidth-1:0] burst_budget;
  cnt_t                 w_budget;

  assign aw_hs    = aw_i.valid && aw_i.ready;
  assign aw_stall = aw_i.valid && !aw_i.ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_q <= '0;
    end else if (flush_i || aw_hs) begin
      stall_q <= '0;
    end else if (aw_stall) begin
      stall_q <= sat_inc(stall_q);
    end
  end

  // Burst budget is the per-beat budget times the number of beats
  assign beats        = {1'b0, aw_i.len} + (LenWidth+1)'(1);
  assign burst_budget = {{(LenWidth+1){1'b0}}, budget_i.w_per_beat} *
                        {{CntWidth{1'b0}}, beats};
  assign w_budget     = (|burst_budget[ProdWidth-1:CntWidth]) ? '1 :
                        burst_budget[CntWidth-1:0];

  assign push_o  = aw_hs && !fifo_full_i;
  assign entry_o = '{id: aw_i.id, len: aw_i.len, aw_wait: stall_q, w_budget: w_budget};

  assign stall_over = stall_q > budget_i.aw_wait;
  assign overflow   = aw_hs && fifo_full_i;

  always_comb begin
    fault_o = '{valid: 1'b0, code: NONE, id: '0};
    if (stall_over) begin
      fault_o = '{valid: 1'b1, code: AW_STALL, id: aw_i.id};
    end else if (overflow) begin
      fault_o = '{valid: 1'b1, code: TXN_OVERFLOW, id: aw_i.id};
    end
  end

endmodule

/* source/wg_txn_fifo.sv */
/*
 * In-order transaction FIFO
 * Circular buffer of tracked writes, head shown combinationally, flushable
 */
`timescale 1ns/10ps

module wg_txn_fifo import wg_pkg::*; #(
  parameter type entry_t = logic
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   flush_i,
  input  logic   push_i,
  input  entry_t data_i,
  input  logic   pop_i,
  output entry_t data_o,
  output logic   empty_o,
  output logic   full_o
);

  localparam int unsigned PtrWidth = $clog2(MaxWrTxns);

  entry_t mem_q [MaxWrTxns];

  // Extra top bit tells full from empty
  logic [PtrWidth:0] wr_ptr_q, rd_ptr_q;
  logic do_push, do_pop;

  assign empty_o = (wr_ptr_q == rd_ptr_q);
  assign full_o  = (wr_ptr_q[PtrWidth] != rd_ptr_q[PtrWidth]) &&
                   (wr_ptr_q[PtrWidth-1:0] == rd_ptr_q[PtrWidth-1:0]);

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  assign data_o = mem_q[rd_ptr_q[PtrWidth-1:0]];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q[PtrWidth-1:0]] <= data_i;
    end
  end

endmodule

/* source/wg_pkg.sv */
/*
 * Write guard shared definitions
 * Sizes, observed channel structs, FIFO entries and fault codes
 */
package wg_pkg;

  localparam int unsigned IdWidth   = 4;
  localparam int unsigned LenWidth  = 8;
  localparam int unsigned CntWidth  = 8;
  localparam int unsigned MaxWrTxns = 4;

  typedef logic [IdWidth-1:0]  id_t;
  typedef logic [LenWidth-1:0] len_t;
  typedef logic [CntWidth-1:0] cnt_t;

  // Observed handshake levels of the write port
  typedef struct packed {
    logic valid;
    logic ready;
    id_t  id;
    len_t len;
  } aw_chan_t;

  typedef struct packed {
    logic valid;
    logic ready;
    logic last;
  } w_chan_t;

  typedef struct packed {
    logic valid;
    logic ready;
    id_t  id;
  } b_chan_t;

  // Budgets in raw clock cycles
  typedef struct packed {
    cnt_t aw_wait;
    cnt_t w_ready;
    cnt_t w_per_beat;
    cnt_t b_wait;
  } budget_t;

  typedef struct packed {
    id_t  id;
    len_t len;
    cnt_t aw_wait;
    cnt_t w_budget;
  } aw_entry_t;

  typedef struct packed {
    id_t  id;
    cnt_t aw_wait;
    cnt_t w_cycles;
  } b_entry_t;

  typedef struct packed {
    id_t  id;
    cnt_t aw_wait;
    cnt_t w_cycles;
    cnt_t b_wait;
  } latency_t;

  typedef enum logic [2:0] {
    NONE          = 3'd0,
    AW_STALL      = 3'd1,
    TXN_OVERFLOW  = 3'd2,
    W_STALL       = 3'd3,
    W_BURST       = 3'd4,
    W_LEN         = 3'd5,
    B_TIMEOUT     = 3'd6,
    UNWANTED_RESP = 3'd7
  } fault_code_e;

  typedef struct packed {
    logic        valid;
    fault_code_e code;
    id_t         id;
  } fault_t;

  // Counters stop at the top value instead of wrapping
  function automatic cnt_t sat_inc(cnt_t cnt);
    return (cnt == '1) ? cnt : cnt + 1'b1;
  endfunction

endpackage
